// File: Makefile
VERILATOR ?= verilator
FILELIST ?= list.f
TOP ?= tb_mem_stage
BUILD_DIR ?= obj_dir
LOG ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert -j 0
FAIL_MSG ?= Testbench failed
PASS_MSG ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) tb/mem_stage_vectors.txt
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
+incdir+rtl
rtl/mem_stage_pkg.sv
rtl/mem_access_ctrl.sv
rtl/mem_data_cache.sv
rtl/mem_wb_master.sv
rtl/mem_stage_top.sv
tb/tb_clock_gen.sv
tb/tb_wb_memory.sv
tb/tb_mem_stage.sv

// File: rtl/mem_access_ctrl.sv
`include "mem_stage_defs.svh"

module mem_access_ctrl (
	input  logic                      i_clock,
	input  logic                      i_arst_n,

	// Execute stage side
	input  mem_stage_pkg::tag_t       i_tag,
	input  logic                      i_mem_read,
	input  logic                      i_mem_write,
	input  logic                      i_mem_flush,
	input  logic                      i_mem_signed,
	input  mem_stage_pkg::mem_width_t i_mem_width,
	input  mem_stage_pkg::addr_t      i_mem_address,
	input  mem_stage_pkg::word_t      i_rd,
	input  mem_stage_pkg::reg_idx_t   i_inst_rd,
	input  mem_stage_pkg::reg_idx_t   i_mem_inst_rd,
	output logic                      o_busy,
	output mem_stage_pkg::tag_t       o_tag,
	output mem_stage_pkg::word_t      o_rd,
	output mem_stage_pkg::reg_idx_t   o_inst_rd,

	// Cache side
	output logic                      o_cache_request,
	output logic                      o_cache_rw,
	output logic                      o_cache_flush,
	output mem_stage_pkg::addr_t      o_cache_address,
	output mem_stage_pkg::word_t      o_cache_wdata,
	input  logic                      i_cache_ready,
	input  mem_stage_pkg::word_t      i_cache_rdata
);

	import mem_stage_pkg::*;

	access_state_t state;
	logic new_op;
	logic mem_op;
	logic done;
	logic [1:0] byte_index;
	word_t rdata_shifted;
	word_t load_value;
	byte_sel_t lane_mask;
	word_t store_lanes;
	word_t merged_word;

	assign new_op = (i_tag != o_tag);
	assign mem_op = i_mem_read | i_mem_write | i_mem_flush;
	assign o_busy = new_op & mem_op;

	assign byte_index = i_mem_address[1:0];
	assign o_cache_address = {i_mem_address[`MEM_ADDR_W-1:2], 2'b00};

	// Load lane extraction and extension
	assign rdata_shifted = i_cache_rdata >> {byte_index, 3'b000};

	always_comb begin
		case (i_mem_width)
			`MEM_WIDTH_BYTE:
				load_value = {{24{i_mem_signed & rdata_shifted[7]}}, rdata_shifted[7:0]};
			`MEM_WIDTH_HALF:
				load_value = {{16{i_mem_signed & rdata_shifted[15]}}, rdata_shifted[15:0]};
			default:
				load_value = i_cache_rdata;
		endcase
	end

	// Lanes touched by a narrow store
	always_comb begin
		case (i_mem_width)
			`MEM_WIDTH_BYTE: begin
				lane_mask = byte_sel_t'(4'b0001 << byte_index);
				store_lanes = {4{i_rd[7:0]}};
			end
			`MEM_WIDTH_HALF: begin
				lane_mask = byte_sel_t'(4'b0011 << {byte_index[1], 1'b0});
				store_lanes = {2{i_rd[15:0]}};
			end
			default: begin
				lane_mask = 4'b1111;
				store_lanes = i_rd;
			end
		endcase
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			merged_word[8*i +: 8] = lane_mask[i] ? store_lanes[8*i +: 8] : i_cache_rdata[8*i +: 8];
		end
	end

	// Operation finishes on this edge
	always_comb begin
		case (state)
			IDLE:       done = new_op & ~mem_op;
			READ,
			WRITE_WORD,
			RMW_WRITE,
			FLUSH:      done = i_cache_ready;
			default:    done = 1'b0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= IDLE;
			o_tag <= '0;
			o_cache_request <= 1'b0;
			o_cache_rw <= 1'b0;
			o_cache_flush <= 1'b0;
		end else begin
			if (done)
				o_tag <= i_tag;

			case (state)
				IDLE: begin
					if (new_op) begin
						if (i_mem_read) begin
							o_cache_request <= 1'b1;
							o_cache_rw <= 1'b0;
							state <= READ;
						end else if (i_mem_write) begin
							o_cache_request <= 1'b1;
							if (i_mem_width == `MEM_WIDTH_WORD) begin
								o_cache_rw <= 1'b1;
								state <= WRITE_WORD;
							end else begin
								// Fetch the containing word first
								o_cache_rw <= 1'b0;
								state <= RMW_READ;
							end
						end else if (i_mem_flush) begin
							o_cache_request <= 1'b1;
							o_cache_flush <= 1'b1;
							state <= FLUSH;
						end
					end
				end

				READ, WRITE_WORD, FLUSH: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						o_cache_rw <= 1'b0;
						o_cache_flush <= 1'b0;
						state <= IDLE;
					end
				end

				RMW_READ: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						state <= RMW_WRITE;
					end
				end

				RMW_WRITE: begin
					// Request stays low for the first cycle here
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						o_cache_rw <= 1'b0;
						state <= IDLE;
					end else begin
						o_cache_request <= 1'b1;
						o_cache_rw <= 1'b1;
					end
				end

				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == IDLE && new_op && i_mem_write)
			o_cache_wdata <= i_rd;
		else if (state == RMW_READ && i_cache_ready)
			o_cache_wdata <= merged_word;

		if (done) begin
			if (state == READ) begin
				o_rd <= load_value;
				o_inst_rd <= i_mem_inst_rd;
			end else begin
				o_rd <= i_rd;
				o_inst_rd <= i_inst_rd;
			end
		end
	end

endmodule

// File: rtl/mem_data_cache.sv
`include "mem_stage_defs.svh"

module mem_data_cache #(
	parameter int INDEX_W = `MEM_CACHE_INDEX_W
) (
	input  logic                 i_clock,
	input  logic                 i_arst_n,

	// Controller side
	input  logic                 i_request,
	input  logic                 i_rw,
	input  logic                 i_flush,
	input  mem_stage_pkg::addr_t i_address,
	input  mem_stage_pkg::word_t i_wdata,
	output logic                 o_ready,
	output mem_stage_pkg::word_t o_rdata,

	// Bus master side
	output logic                 o_bus_request,
	output logic                 o_bus_rw,
	output mem_stage_pkg::addr_t o_bus_address,
	output mem_stage_pkg::word_t o_bus_wdata,
	input  logic                 i_bus_ready,
	input  mem_stage_pkg::word_t i_bus_rdata
);

	import mem_stage_pkg::*;

	localparam int LINES = 1 << INDEX_W;
	localparam int LINE_TAG_W = `MEM_ADDR_W - INDEX_W - 2;

	cache_state_t state;
	logic [LINES-1:0] valid;
	logic [LINE_TAG_W-1:0] tag_array [LINES];
	word_t data_array [LINES];
	logic [INDEX_W-1:0] flush_index;

	logic cacheable;
	logic [INDEX_W-1:0] index;
	logic [LINE_TAG_W-1:0] line_tag;
	logic hit;
	logic line_write;

	assign cacheable = (i_address[`MEM_ADDR_W-1:`MEM_ADDR_W-4] == `MEM_CACHEABLE_REGION);
	assign index = i_address[INDEX_W+1:2];
	assign line_tag = i_address[`MEM_ADDR_W-1:INDEX_W+2];
	assign hit = cacheable & valid[index] & (tag_array[index] == line_tag);

	// Fill on cacheable read, update on write hit
	assign line_write = (state == CACHE_BUS) & i_bus_ready & cacheable & (~i_rw | hit);

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= CACHE_IDLE;
			valid <= '0;
			flush_index <= '0;
			o_ready <= 1'b0;
			o_bus_request <= 1'b0;
			o_bus_rw <= 1'b0;
		end else begin
			case (state)
				CACHE_IDLE: begin
					if (i_request) begin
						if (i_flush) begin
							flush_index <= '0;
							state <= CACHE_FLUSH;
						end else if (!i_rw && hit) begin
							o_ready <= 1'b1;
							state <= CACHE_DONE;
						end else begin
							o_bus_request <= 1'b1;
							o_bus_rw <= i_rw;
							state <= CACHE_BUS;
						end
					end
				end

				CACHE_BUS: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_bus_rw <= 1'b0;
						o_ready <= 1'b1;
						if (line_write)
							valid[index] <= 1'b1;
						state <= CACHE_DONE;
					end
				end

				CACHE_FLUSH: begin
					valid[flush_index] <= 1'b0;
					flush_index <= flush_index + 1'b1;
					if (&flush_index) begin
						o_ready <= 1'b1;
						state <= CACHE_DONE;
					end
				end

				CACHE_DONE: begin
					// Requester drops its request during this cycle
					o_ready <= 1'b0;
					state <= CACHE_IDLE;
				end

				default: state <= CACHE_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == CACHE_IDLE && i_request && !i_flush) begin
			o_bus_address <= i_address;
			o_bus_wdata <= i_wdata;
			o_rdata <= data_array[index];
		end

		if (state == CACHE_BUS && i_bus_ready)
			o_rdata <= i_bus_rdata;

		if (line_write) begin
			tag_array[index] <= line_tag;
			data_array[index] <= i_rw ? i_wdata : i_bus_rdata;
		end
	end

endmodule

// File: rtl/mem_stage_defs.svh
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// Datapath widths
`define MEM_DATA_W 32
`define MEM_ADDR_W 32
`define MEM_TAG_W 4
`define MEM_REG_W 5

// 64 one-word lines by default
`define MEM_CACHE_INDEX_W 6

// Address bits 31:28 of the SDRAM window
`define MEM_CACHEABLE_REGION 4'h2

// Access width codes
`define MEM_WIDTH_BYTE 2'd0
`define MEM_WIDTH_HALF 2'd1
`define MEM_WIDTH_WORD 2'd2

`endif

// File: rtl/mem_stage_pkg.sv
`include "mem_stage_defs.svh"

package mem_stage_pkg;

	typedef logic [`MEM_DATA_W-1:0] word_t;
	typedef logic [`MEM_ADDR_W-1:0] addr_t;
	typedef logic [`MEM_TAG_W-1:0] tag_t;
	typedef logic [`MEM_REG_W-1:0] reg_idx_t;
	typedef logic [3:0] byte_sel_t;
	typedef logic [1:0] mem_width_t;

	// Pipeline-side access sequencing
	typedef enum logic [2:0] {
		IDLE,
		READ,
		WRITE_WORD,
		RMW_READ,
		RMW_WRITE,
		FLUSH
	} access_state_t;

	typedef enum logic [1:0] {
		CACHE_IDLE,
		CACHE_BUS,
		CACHE_FLUSH,
		CACHE_DONE
	} cache_state_t;

endpackage

// File: rtl/mem_stage_top.sv
module mem_stage_top (
	input  logic                      i_clock,
	input  logic                      i_arst_n,

	// Pipeline
	input  mem_stage_pkg::tag_t       i_tag,
	input  logic                      i_mem_read,
	input  logic                      i_mem_write,
	input  logic                      i_mem_flush,
	input  logic                      i_mem_signed,
	input  mem_stage_pkg::mem_width_t i_mem_width,
	input  mem_stage_pkg::addr_t      i_mem_address,
	input  mem_stage_pkg::word_t      i_rd,
	input  mem_stage_pkg::reg_idx_t   i_inst_rd,
	input  mem_stage_pkg::reg_idx_t   i_mem_inst_rd,
	output logic                      o_busy,
	output mem_stage_pkg::tag_t       o_tag,
	output mem_stage_pkg::word_t      o_rd,
	output mem_stage_pkg::reg_idx_t   o_inst_rd,

	// Wishbone
	output logic                      o_wb_cyc,
	output logic                      o_wb_stb,
	output logic                      o_wb_we,
	output mem_stage_pkg::addr_t      o_wb_adr,
	output mem_stage_pkg::byte_sel_t  o_wb_sel,
	output mem_stage_pkg::word_t      o_wb_dat,
	input  mem_stage_pkg::word_t      i_wb_dat,
	input  logic                      i_wb_ack
);

	import mem_stage_pkg::*;

	logic cache_request;
	logic cache_rw;
	logic cache_flush;
	addr_t cache_address;
	word_t cache_wdata;
	logic cache_ready;
	word_t cache_rdata;

	logic bus_request;
	logic bus_rw;
	addr_t bus_address;
	word_t bus_wdata;
	logic bus_ready;
	word_t bus_rdata;

	mem_access_ctrl access_ctrl_i (
		.i_clock         (i_clock),
		.i_arst_n        (i_arst_n),
		.i_tag           (i_tag),
		.i_mem_read      (i_mem_read),
		.i_mem_write     (i_mem_write),
		.i_mem_flush     (i_mem_flush),
		.i_mem_signed    (i_mem_signed),
		.i_mem_width     (i_mem_width),
		.i_mem_address   (i_mem_address),
		.i_rd            (i_rd),
		.i_inst_rd       (i_inst_rd),
		.i_mem_inst_rd   (i_mem_inst_rd),
		.o_busy          (o_busy),
		.o_tag           (o_tag),
		.o_rd            (o_rd),
		.o_inst_rd       (o_inst_rd),
		.o_cache_request (cache_request),
		.o_cache_rw      (cache_rw),
		.o_cache_flush   (cache_flush),
		.o_cache_address (cache_address),
		.o_cache_wdata   (cache_wdata),
		.i_cache_ready   (cache_ready),
		.i_cache_rdata   (cache_rdata)
	);

	mem_data_cache data_cache_i (
		.i_clock       (i_clock),
		.i_arst_n      (i_arst_n),
		.i_request     (cache_request),
		.i_rw          (cache_rw),
		.i_flush       (cache_flush),
		.i_address     (cache_address),
		.i_wdata       (cache_wdata),
		.o_ready       (cache_ready),
		.o_rdata       (cache_rdata),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata)
	);

	mem_wb_master wb_master_i (
		.i_clock   (i_clock),
		.i_arst_n  (i_arst_n),
		.i_request (bus_request),
		.i_rw      (bus_rw),
		.i_address (bus_address),
		.i_wdata   (bus_wdata),
		.o_ready   (bus_ready),
		.o_rdata   (bus_rdata),
		.o_wb_cyc  (o_wb_cyc),
		.o_wb_stb  (o_wb_stb),
		.o_wb_we   (o_wb_we),
		.o_wb_adr  (o_wb_adr),
		.o_wb_sel  (o_wb_sel),
		.o_wb_dat  (o_wb_dat),
		.i_wb_dat  (i_wb_dat),
		.i_wb_ack  (i_wb_ack)
	);

endmodule

// File: rtl/mem_wb_master.sv
module mem_wb_master (
	input  logic                     i_clock,
	input  logic                     i_arst_n,

	// Cache side
	input  logic                     i_request,
	input  logic                     i_rw,
	input  mem_stage_pkg::addr_t     i_address,
	input  mem_stage_pkg::word_t     i_wdata,
	output logic                     o_ready,
	output mem_stage_pkg::word_t     o_rdata,

	// Wishbone classic
	output logic                     o_wb_cyc,
	output logic                     o_wb_stb,
	output logic                     o_wb_we,
	output mem_stage_pkg::addr_t     o_wb_adr,
	output mem_stage_pkg::byte_sel_t o_wb_sel,
	output mem_stage_pkg::word_t     o_wb_dat,
	input  mem_stage_pkg::word_t     i_wb_dat,
	input  logic                     i_wb_ack
);

	import mem_stage_pkg::*;

	logic start;

	// Lanes are merged before the bus
	assign o_wb_sel = '1;

	assign start = i_request & ~o_wb_cyc & ~o_ready;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
			o_wb_we <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			if (o_wb_cyc) begin
				if (i_wb_ack) begin
					o_wb_cyc <= 1'b0;
					o_wb_stb <= 1'b0;
					o_wb_we <= 1'b0;
					o_ready <= 1'b1;
				end
			end else if (o_ready) begin
				o_ready <= 1'b0;
			end else if (i_request) begin
				o_wb_cyc <= 1'b1;
				o_wb_stb <= 1'b1;
				o_wb_we <= i_rw;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (start) begin
			o_wb_adr <= i_address;
			o_wb_dat <= i_wdata;
		end
		if (o_wb_cyc && i_wb_ack)
			o_rdata <= i_wb_dat;
	end

endmodule

// File: tb/mem_stage_vectors.txt
# name op(0 pass,1 load,2 store,3 flush) width(0 byte,1 half,2 word) signed address wdata
#   expected_o_rd (wdata for non-loads) expected_bus_cycles, numbers in hex except the codes
pass_first 0 2 0 00000000 600dcafe 600dcafe 0
st_word_cached 2 2 0 20000100 11223344 11223344 1
ld_word_cached 1 2 0 20000100 00000000 11223344 1
ld_word_cached_hit 1 2 0 20000100 00000000 11223344 0
st_word_periph 2 2 0 10000200 cafef00d cafef00d 1
ld_word_periph 1 2 0 10000200 00000000 cafef00d 1
st_byte_lane1 2 0 0 10000201 123456a5 123456a5 2
ld_after_byte1 1 2 0 10000200 00000000 cafea50d 1
st_half_upper 2 1 0 10000202 0000beef 0000beef 2
ld_after_half_upper 1 2 0 10000200 00000000 beefa50d 1
st_byte_lane3 2 0 0 10000203 ffffff80 ffffff80 2
st_byte_lane0 2 0 0 10000200 0000007f 0000007f 2
ld_after_bytes 1 2 0 10000200 00000000 80efa57f 1
st_half_lower 2 1 0 10000200 9abc1234 9abc1234 2
ld_after_half_lower 1 2 0 10000200 00000000 80ef1234 1
st_byte_sdram_miss 2 0 0 20000141 0000003c 0000003c 2
ld_sdram_merged_hit 1 2 0 20000140 00000000 5b1a3ca5 0
st_word_sdram_hit 2 2 0 20000100 8a7ff001 8a7ff001 1
ld_byte_s_lane1 1 0 1 20000101 00000000 fffffff0 0
ld_byte_u_lane1 1 0 0 20000101 00000000 000000f0 0
ld_byte_s_lane2 1 0 1 20000102 00000000 0000007f 0
ld_byte_s_lane3 1 0 1 20000103 00000000 ffffff8a 0
ld_byte_u_lane0 1 0 0 20000100 00000000 00000001 0
ld_half_s_lower 1 1 1 20000100 00000000 fffff001 0
ld_half_u_lower 1 1 0 20000100 00000000 0000f001 0
ld_half_s_upper 1 1 1 20000102 00000000 ffff8a7f 0
ld_half_u_upper 1 1 0 20000102 00000000 00008a7f 0
ld_repeat_sdram_1 1 2 0 200001c0 00000000 5b9a85a5 1
ld_repeat_sdram_2 1 2 0 200001c0 00000000 5b9a85a5 0
ld_repeat_sdram_3 1 2 0 200001c0 00000000 5b9a85a5 0
ld_repeat_periph_1 1 2 0 10000200 00000000 80ef1234 1
ld_repeat_periph_2 1 2 0 10000200 00000000 80ef1234 1
flush_all 3 2 0 00000000 00000000 00000000 0
ld_after_flush 1 2 0 200001c0 00000000 5b9a85a5 1
ld_after_flush_hit 1 2 0 200001c0 00000000 5b9a85a5 0
ld_refill_after_flush 1 2 0 20000100 00000000 8a7ff001 1
ld_byte_s_periph 1 0 1 10000203 00000000 ffffff80 1
pass_last 0 0 1 20000100 13579bdf 13579bdf 0

// File: tb/tb_clock_gen.sv
module tb_clock_gen (
	output logic o_clock,
	output logic o_arst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period
	initial begin
		o_clock = 1'b0;
		forever #20 o_clock = ~o_clock;
	end

	// Reset low over the first four rising edges
	initial begin
		o_arst_n <= 1'b0;
		repeat (4) @(posedge o_clock);
		o_arst_n <= 1'b1;
	end

endmodule

// File: tb/tb_mem_stage.sv
module tb_mem_stage;

	timeunit 1ns;
	timeprecision 1ps;

	import mem_stage_pkg::*;

	localparam int DONE_TIMEOUT = 400;
	localparam int RESET_TIMEOUT = 20;
	localparam int OP_PASS = 0;
	localparam int OP_LOAD = 1;
	localparam int OP_STORE = 2;
	localparam int OP_FLUSH = 3;

	logic clock;
	logic arst_n;

	tag_t tag;
	logic mem_read;
	logic mem_write;
	logic mem_flush;
	logic mem_signed;
	mem_width_t mem_width;
	addr_t mem_address;
	word_t rd_in;
	reg_idx_t inst_rd_in;
	reg_idx_t mem_inst_rd_in;
	logic busy;
	tag_t tag_out;
	word_t rd_out;
	reg_idx_t inst_rd_out;

	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	addr_t wb_adr;
	byte_sel_t wb_sel;
	word_t wb_dat_w;
	word_t wb_dat_r;
	logic wb_ack;

	int fd;
	string line;
	string name;
	int op;
	int width;
	int is_signed;
	logic [31:0] address;
	logic [31:0] wdata;
	logic [31:0] expected_rd;
	int expected_cycles;
	int errors;
	int test_errors;
	int tests;
	int failed_tests;
	bit timed_out;
	bit line_ok;
	tag_t next_tag;

	tb_clock_gen clock_gen_i (
		.o_clock  (clock),
		.o_arst_n (arst_n)
	);

	mem_stage_top mem_stage_top_i (
		.i_clock       (clock),
		.i_arst_n      (arst_n),
		.i_tag         (tag),
		.i_mem_read    (mem_read),
		.i_mem_write   (mem_write),
		.i_mem_flush   (mem_flush),
		.i_mem_signed  (mem_signed),
		.i_mem_width   (mem_width),
		.i_mem_address (mem_address),
		.i_rd          (rd_in),
		.i_inst_rd     (inst_rd_in),
		.i_mem_inst_rd (mem_inst_rd_in),
		.o_busy        (busy),
		.o_tag         (tag_out),
		.o_rd          (rd_out),
		.o_inst_rd     (inst_rd_out),
		.o_wb_cyc      (wb_cyc),
		.o_wb_stb      (wb_stb),
		.o_wb_we       (wb_we),
		.o_wb_adr      (wb_adr),
		.o_wb_sel      (wb_sel),
		.o_wb_dat      (wb_dat_w),
		.i_wb_dat      (wb_dat_r),
		.i_wb_ack      (wb_ack)
	);

	tb_wb_memory wb_memory_i (
		.i_clock  (clock),
		.i_arst_n (arst_n),
		.i_wb_cyc (wb_cyc),
		.i_wb_stb (wb_stb),
		.i_wb_we  (wb_we),
		.i_wb_adr (wb_adr),
		.i_wb_sel (wb_sel),
		.i_wb_dat (wb_dat_w),
		.o_wb_dat (wb_dat_r),
		.o_wb_ack (wb_ack)
	);

	task automatic wait_for_reset();
		int cycles;
		cycles = 0;
		while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (arst_n !== 1'b1) begin
			$display("Timeout: reset was never released");
			timed_out = 1'b1;
		end
	endtask

	// Splits one vector line into the name and the numeric fields
	task automatic parse_line(output bit ok);
		int space_pos;
		string rest;
		ok = 1'b0;
		space_pos = 0;
		if (line.len() < 2 || line.getc(0) == "#")
			return;
		while (space_pos < line.len() && line.getc(space_pos) != " ")
			space_pos++;
		if (space_pos == 0 || space_pos >= line.len() - 1) begin
			$display("Malformed vector line, no fields after the name");
			errors++;
			return;
		end
		name = line.substr(0, space_pos - 1);
		rest = line.substr(space_pos + 1, line.len() - 1);
		ok = ($sscanf(rest, "%d %d %d %h %h %h %d", op, width, is_signed,
			address, wdata, expected_rd, expected_cycles) == 7);
		if (!ok) begin
			$display("Malformed vector line for %s, expected seven fields", name);
			errors++;
		end
	endtask

	task automatic drive_operation(input tag_t new_tag);
		@(posedge clock);
		tag <= new_tag;
		mem_read <= (op == OP_LOAD);
		mem_write <= (op == OP_STORE);
		mem_flush <= (op == OP_FLUSH);
		mem_signed <= (is_signed != 0);
		mem_width <= mem_width_t'(width);
		mem_address <= address;
		rd_in <= wdata;
		inst_rd_in <= reg_idx_t'(tests);
		mem_inst_rd_in <= reg_idx_t'(tests + 16);
	endtask

	// o_busy must stay at expect_busy until the tag comes back
	task automatic wait_for_completion(input tag_t new_tag, input logic expect_busy);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (tag_out != new_tag && cycles < DONE_TIMEOUT) begin
			assert (busy == expect_busy) else begin
				$display("Error: %s o_busy expected %0b actual %0b", name, expect_busy, busy);
				test_errors++;
			end
			cycles++;
			@(negedge clock);
		end
		if (tag_out != new_tag) begin
			$display("Timeout: %s did not complete within %0d cycles", name, DONE_TIMEOUT);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_test();
		int start_count;
		int bus_cycles;
		reg_idx_t expected_inst_rd;
		tests++;
		test_errors = 0;
		next_tag = tag_t'(next_tag + 1);
		@(negedge clock);
		start_count = int'(wb_memory_i.cycle_count);
		drive_operation(next_tag);
		wait_for_completion(next_tag, op != OP_PASS);
		if (!timed_out) begin
			bus_cycles = int'(wb_memory_i.cycle_count) - start_count;
			// Only a load returns the load destination
			expected_inst_rd = (op == OP_LOAD) ? reg_idx_t'(tests + 16) : reg_idx_t'(tests);
			assert (rd_out == expected_rd) else begin
				$display("Error: %s o_rd expected %h actual %h", name, expected_rd, rd_out);
				test_errors++;
			end
			assert (inst_rd_out == expected_inst_rd) else begin
				$display("Error: %s o_inst_rd expected %0d actual %0d", name,
					expected_inst_rd, inst_rd_out);
				test_errors++;
			end
			assert (bus_cycles == expected_cycles) else begin
				$display("Error: %s bus cycles expected %0d actual %0d", name,
					expected_cycles, bus_cycles);
				test_errors++;
			end
			assert (!busy) else begin
				$display("Error: %s o_busy expected 0 actual 1", name);
				test_errors++;
			end
		end
		if (test_errors == 0 && !timed_out) begin
			$display("Test %0d %s: ok", tests, name);
		end else begin
			$display("Test %0d %s: FAILED", tests, name);
			failed_tests++;
		end
		errors += test_errors;
	endtask

	initial begin
		tag <= '0;
		mem_read <= 1'b0;
		mem_write <= 1'b0;
		mem_flush <= 1'b0;
		mem_signed <= 1'b0;
		mem_width <= '0;
		mem_address <= '0;
		rd_in <= '0;
		inst_rd_in <= '0;
		mem_inst_rd_in <= '0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		timed_out = 1'b0;
		next_tag = '0;

		wait_for_reset();
		if (!timed_out) begin
			fd = $fopen("tb/mem_stage_vectors.txt", "r");
			if (fd == 0) begin
				$display("Could not open the vector file tb/mem_stage_vectors.txt");
				errors++;
			end else begin
				while (!timed_out && $fgets(line, fd) != 0) begin
					parse_line(line_ok);
					if (line_ok)
						run_test();
				end
				$fclose(fd);
			end
		end

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors);
		if (errors == 0 && !timed_out && tests > 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: tb/tb_wb_memory.sv
module tb_wb_memory (
	input  logic        i_clock,
	input  logic        i_arst_n,
	input  logic        i_wb_cyc,
	input  logic        i_wb_stb,
	input  logic        i_wb_we,
	input  logic [31:0] i_wb_adr,
	input  logic [3:0]  i_wb_sel,
	input  logic [31:0] i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic        o_wb_ack
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WORDS = 1024;

	logic [31:0] mem [WORDS];
	logic [WORDS-1:0] written;
	logic active;
	logic [1:0] wait_count;
	logic [9:0] index;
	logic [31:0] current;
	logic [31:0] merged;
	integer seed = 32'hc672;
	int unsigned cycle_count;

	// Unwritten words read back as a function of the full address
	function automatic logic [31:0] fill_word(input logic [31:0] adr);
		return {adr[15:0], adr[31:16]} ^ 32'h5a5a_a5a5;
	endfunction

	// Region bits keep SDRAM and peripheral words apart
	assign index = {i_wb_adr[29:28], i_wb_adr[9:2]};
	assign current = written[index] ? mem[index] : fill_word(i_wb_adr);

	always_comb begin
		for (int i = 0; i < 4; i++)
			merged[8*i +: 8] = i_wb_sel[i] ? i_wb_dat[8*i +: 8] : current[8*i +: 8];
	end

	always @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wb_ack <= 1'b0;
			o_wb_dat <= '0;
			active <= 1'b0;
			wait_count <= 2'd0;
			written <= '0;
			cycle_count <= 0;
		end else begin
			o_wb_ack <= 1'b0;
			if (i_wb_cyc && i_wb_stb && !o_wb_ack) begin
				if (!active) begin
					// New strobe cycle, 0 to 3 wait states
					active <= 1'b1;
					wait_count <= 2'($random(seed));
					cycle_count <= cycle_count + 1;
				end else if (wait_count != 2'd0) begin
					wait_count <= wait_count - 2'd1;
				end else begin
					active <= 1'b0;
					o_wb_ack <= 1'b1;
					o_wb_dat <= current;
					if (i_wb_we) begin
						mem[index] <= merged;
						written[index] <= 1'b1;
					end
				end
			end
		end
	end

endmodule
